//--- sources.f
+incdir+rtl
rtl/csrPkg.sv
rtl/csrStatus.sv
rtl/csrInterrupt.sv
rtl/csrm.sv
rtl/csrUnit.sv
tests/tbClock.sv
tests/csrUnit_chk.sv
tests/csrUnitTb.sv

//--- Makefile
# Verilator build and run for the machine CSR unit testbench

VERILATOR ?= verilator
TOP       ?= csrUnitTb
FILELIST  ?= sources.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASSMSG   ?= All tests passed!

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard rtl/*.svh)
BIN     := $(OBJDIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source, header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "$(PASSMSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- tests/csrUnitTb.sv
/*
  Testbench for the machine CSR unit
  Builds a table of CSR accesses, traps, mret and interrupt
  line changes, applies it one row per cycle and checks
  readVal, illegal and the interrupt outputs of every row
*/
`timescale 1ns/1ps
`default_nettype none
`include "csr_params.svh"

module csrUnitTb;

  typedef enum logic [1:0] {
    KindAccess,
    KindTrap,
    KindMret,
    KindIrq
  } rowKindT;

  // One strobe with its stimulus and expected response
  typedef struct packed {
    rowKindT       kind;
    csrPkg::csrOpT op;
    logic [11:0]   adr;
    logic [31:0]   src;
    logic [4:0]    cause;
    logic [31:0]   epc;
    logic [31:0]   tval;
    logic [2:0]    mip;
    logic          chkRead;
    logic [31:0]   expRead;
    logic          expIll;
    logic          expPend;
    logic [4:0]    expCause;
    logic [31:0]   expMtvec;
    logic [31:0]   expMepc;
  } rowT;

  logic          clk;
  logic          rstN;
  logic          csrEn;
  csrPkg::csrOpT csrOp;
  logic [11:0]   csrAdr;
  logic [31:0]   csrSrc;
  logic          trap;
  logic [4:0]    trapCause;
  logic [31:0]   trapEpc;
  logic [31:0]   trapTval;
  logic          mret;
  logic [2:0]    mipIn;
  logic [31:0]   readVal;
  logic          illegal;
  logic [31:0]   mtvec;
  logic [31:0]   mepc;
  logic          irqPending;
  logic [4:0]    irqCause;

  rowT         rows[$];
  int          errors;
  int          checks;
  bit          tableReady = 1'b0;
  // Reference state while the table is built
  logic [31:0] rnd;
  logic        gMie;
  logic [2:0]  mieEn;
  logic [2:0]  curMip;
  logic [31:0] scratchModel;
  logic [31:0] mtvecModel;
  logic [31:0] mepcModel;

  tbClock i_tbClock (
    .clk  (clk),
    .rstN (rstN)
  );

  csrUnit i_csrUnit (
    .clk        (clk),
    .rstN       (rstN),
    .csrEn      (csrEn),
    .csrOp      (csrOp),
    .csrAdr     (csrAdr),
    .csrSrc     (csrSrc),
    .trap       (trap),
    .trapCause  (trapCause),
    .trapEpc    (trapEpc),
    .trapTval   (trapTval),
    .mret       (mret),
    .mipIn      (mipIn),
    .readVal    (readVal),
    .illegal    (illegal),
    .mtvec      (mtvec),
    .mepc       (mepc),
    .irqPending (irqPending),
    .irqCause   (irqCause)
  );

  bind csrUnit csrUnitChk i_csrUnitChk (
    .clk        (clk),
    .rstN       (rstN),
    .csrEn      (csrEn),
    .illegal    (illegal),
    .trap       (trap),
    .mret       (mret),
    .writeEn    (writeEn),
    .csrAdr     (csrAdr),
    .mtvec      (mtvec),
    .mepc       (mepc),
    .mstatusReg (mstatusReg),
    .irqPending (irqPending)
  );

  ////////////////////////////////////////////////////////////
  // Reference rules

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // New register value for each CSR opcode
  function automatic logic [31:0] applyOp(input csrPkg::csrOpT op, input logic [31:0] old,
                                          input logic [31:0] src);
    case (op)
      csrPkg::CsrRw: return src;
      csrPkg::CsrRs: return old | src;
      default:       return old & ~src;
    endcase
  endfunction

  // Lines are external, timer, software; external wins, then software
  function automatic logic [4:0] expectedCause(input logic [2:0] lines);
    if (lines[2])      return 5'h1B;
    else if (lines[0]) return 5'h13;
    else if (lines[1]) return 5'h17;
    return 5'h00;
  endfunction

  ////////////////////////////////////////////////////////////
  // Table construction

  task automatic finishRow(input rowT r);
    r.mip      = curMip;
    r.expPend  = gMie & (|(curMip & mieEn));
    r.expCause = expectedCause(curMip & mieEn);
    // Fetch stage outputs still show the state before this strobe
    r.expMtvec = mtvecModel;
    r.expMepc  = mepcModel;
    rows.push_back(r);
  endtask

  task automatic addAccess(input csrPkg::csrOpT op, input logic [11:0] adr,
                           input logic [31:0] src, input logic chk,
                           input logic [31:0] expRead, input logic expIll);
    rowT r;
    r         = '0;
    r.kind    = KindAccess;
    r.op      = op;
    r.adr     = adr;
    r.src     = src;
    r.chkRead = chk;
    r.expRead = expRead;
    r.expIll  = expIll;
    finishRow(r);
  endtask

  // Trap, mret or a change of the interrupt lines
  task automatic addEvent(input rowKindT kind, input logic [4:0] cause,
                          input logic [31:0] epc, input logic [31:0] tval);
    rowT r;
    r       = '0;
    r.kind  = kind;
    r.op    = csrPkg::CsrRs;
    r.cause = cause;
    r.epc   = epc;
    r.tval  = tval;
    finishRow(r);
  endtask

  task automatic addIrq(input logic [2:0] lines);
    curMip = lines;
    addEvent(KindIrq, 5'h00, 32'h0, 32'h0);
  endtask

  task automatic buildTable();
    logic [31:0]   src;
    csrPkg::csrOpT op;
    rnd          = 32'ha4c3617a;
    gMie         = 1'b0;
    mieEn        = 3'b000;
    curMip       = 3'b000;
    scratchModel = 32'h0;
    mtvecModel   = 32'h0;
    mepcModel    = 32'h0;
    // Reset and fixed values, set or clear with zero source only reads
    addAccess(csrPkg::CsrRs, 12'h300, 32'h0, 1'b1, 32'h0000_1800, 1'b0);
    addAccess(csrPkg::CsrRs, 12'h301, 32'h0, 1'b1, `MISA_VAL, 1'b0);
    addAccess(csrPkg::CsrRc, 12'hF11, 32'h0, 1'b1, `VENDOR_ID, 1'b0);
    addAccess(csrPkg::CsrRs, 12'hF12, 32'h0, 1'b1, `ARCH_ID, 1'b0);
    addAccess(csrPkg::CsrRs, 12'hF13, 32'h0, 1'b1, `IMP_ID, 1'b0);
    addAccess(csrPkg::CsrRs, 12'hF14, 32'h0, 1'b1, 32'h0, 1'b0);
    // Random opcodes and sources, mscratch first then mtvec
    for (int i = 0; i < 12; i++) begin
      rnd = lcgNext(rnd);
      src = rnd;
      rnd = lcgNext(rnd);
      op  = csrPkg::csrOpT'(2'(1 + rnd[31:16] % 3));
      if (i < 6) begin
        addAccess(op, 12'h340, src, 1'b1, scratchModel, 1'b0);
        scratchModel = applyOp(op, scratchModel, src);
      end else begin
        addAccess(op, 12'h305, src, 1'b1, mtvecModel, 1'b0);
        // Bit 1 of mtvec always reads zero
        mtvecModel = applyOp(op, mtvecModel, src) & ~32'h2;
      end
    end
    addAccess(csrPkg::CsrRs, 12'h340, 32'h0, 1'b1, scratchModel, 1'b0);
    addAccess(csrPkg::CsrRw, 12'h305, 32'hFFFF_FFFF, 1'b1, mtvecModel, 1'b0);
    mtvecModel = 32'hFFFF_FFFD;
    addAccess(csrPkg::CsrRs, 12'h305, 32'h0, 1'b1, 32'hFFFF_FFFD, 1'b0);
    // Illegal addresses and identity writes
    addAccess(csrPkg::CsrRw, 12'h7C0, 32'h1234_5678, 1'b0, 32'h0, 1'b1);
    addAccess(csrPkg::CsrRw, 12'h302, 32'hFFFF_FFFF, 1'b0, 32'h0, 1'b1);
    addAccess(csrPkg::CsrRs, 12'h303, 32'h0, 1'b0, 32'h0, 1'b1);
    addAccess(csrPkg::CsrRw, 12'h30A, 32'h0000_00F1, 1'b0, 32'h0, 1'b1);
    addAccess(csrPkg::CsrRw, 12'h310, 32'hFFFF_FFFF, 1'b1, 32'h0, 1'b0);
    addAccess(csrPkg::CsrRs, 12'h310, 32'h0, 1'b1, 32'h0, 1'b0);
    addAccess(csrPkg::CsrRw, 12'hF11, 32'h5, 1'b0, 32'h0, 1'b1);
    addAccess(csrPkg::CsrRs, 12'hF12, 32'h1, 1'b0, 32'h0, 1'b1);
    addAccess(csrPkg::CsrRc, 12'hF13, 32'hFFF, 1'b0, 32'h0, 1'b1);
    addAccess(csrPkg::CsrRw, 12'hF14, 32'h0, 1'b0, 32'h0, 1'b1);
    addAccess(csrPkg::CsrRw, 12'hF15, 32'h7, 1'b0, 32'h0, 1'b1);
    addAccess(csrPkg::CsrRs, 12'hF12, 32'h0, 1'b1, `ARCH_ID, 1'b0);
    addAccess(csrPkg::CsrRs, 12'hF13, 32'h0, 1'b1, `IMP_ID, 1'b0);
    addAccess(csrPkg::CsrRs, 12'h340, 32'h0, 1'b1, scratchModel, 1'b0);
    // Trap entry and return, MIE stacks into MPIE
    addAccess(csrPkg::CsrRw, 12'h300, 32'h8, 1'b1, 32'h1800, 1'b0);
    gMie = 1'b1;
    addAccess(csrPkg::CsrRs, 12'h300, 32'h0, 1'b1, 32'h1808, 1'b0);
    addEvent(KindTrap, 5'h1B, 32'h8000_0100, 32'h0000_0BAD);
    gMie      = 1'b0;
    mepcModel = 32'h8000_0100;
    addAccess(csrPkg::CsrRs, 12'h341, 32'h0, 1'b1, 32'h8000_0100, 1'b0);
    addAccess(csrPkg::CsrRs, 12'h343, 32'h0, 1'b1, 32'h0000_0BAD, 1'b0);
    addAccess(csrPkg::CsrRs, 12'h342, 32'h0, 1'b1, 32'h8000_000B, 1'b0);
    addAccess(csrPkg::CsrRs, 12'h300, 32'h0, 1'b1, 32'h1880, 1'b0);
    addEvent(KindMret, 5'h00, 32'h0, 32'h0);
    gMie = 1'b1;
    addAccess(csrPkg::CsrRs, 12'h300, 32'h0, 1'b1, 32'h1888, 1'b0);
    addEvent(KindTrap, 5'h02, 32'h8000_0204, 32'hDEAD_BEEF);
    gMie      = 1'b0;
    mepcModel = 32'h8000_0204;
    addAccess(csrPkg::CsrRs, 12'h341, 32'h0, 1'b1, 32'h8000_0204, 1'b0);
    addAccess(csrPkg::CsrRs, 12'h343, 32'h0, 1'b1, 32'hDEAD_BEEF, 1'b0);
    addAccess(csrPkg::CsrRs, 12'h342, 32'h0, 1'b1, 32'h0000_0002, 1'b0);
    addAccess(csrPkg::CsrRs, 12'h300, 32'h0, 1'b1, 32'h1880, 1'b0);
    addAccess(csrPkg::CsrRw, 12'h341, 32'h8000_0300, 1'b1, 32'h8000_0204, 1'b0);
    mepcModel = 32'h8000_0300;
    addAccess(csrPkg::CsrRs, 12'h341, 32'h0, 1'b1, 32'h8000_0300, 1'b0);
    addEvent(KindMret, 5'h00, 32'h0, 32'h0);
    gMie = 1'b1;
    addAccess(csrPkg::CsrRs, 12'h300, 32'h0, 1'b1, 32'h1888, 1'b0);
    // Interrupts, every line combination with all enables set
    addAccess(csrPkg::CsrRw, 12'h304, 32'h0000_0888, 1'b1, 32'h0, 1'b0);
    mieEn = 3'b111;
    for (int m = 0; m < 8; m++) begin
      addIrq(3'(m));
    end
    addAccess(csrPkg::CsrRs, 12'h344, 32'h0, 1'b1, 32'h888, 1'b0);
    addAccess(csrPkg::CsrRs, 12'h304, 32'h0, 1'b1, 32'h888, 1'b0);
    addAccess(csrPkg::CsrRc, 12'h300, 32'h8, 1'b1, 32'h1888, 1'b0);
    gMie = 1'b0;
    addIrq(3'b111);
    addAccess(csrPkg::CsrRs, 12'h300, 32'h8, 1'b1, 32'h1880, 1'b0);
    gMie = 1'b1;
    addIrq(3'b010);
    addAccess(csrPkg::CsrRc, 12'h304, 32'h80, 1'b1, 32'h888, 1'b0);
    mieEn = 3'b101;
    addIrq(3'b010);
    addIrq(3'b000);
    // PMP, entry 1 locked in TOR mode freezes pmpaddr0 and pmpaddr1
    addAccess(csrPkg::CsrRw, 12'h3B0, 32'h1111_1111, 1'b1, 32'h0, 1'b0);
    addAccess(csrPkg::CsrRw, 12'h3B1, 32'h2222_2222, 1'b1, 32'h0, 1'b0);
    addAccess(csrPkg::CsrRw, 12'h3B2, 32'h3333_3333, 1'b1, 32'h0, 1'b0);
    addAccess(csrPkg::CsrRw, 12'h3A0, 32'h0000_8800, 1'b1, 32'h0, 1'b0);
    addAccess(csrPkg::CsrRs, 12'h3A0, 32'h0, 1'b1, 32'h0000_8800, 1'b0);
    addAccess(csrPkg::CsrRw, 12'h3B0, 32'hAAAA_AAAA, 1'b1, 32'h1111_1111, 1'b0);
    addAccess(csrPkg::CsrRs, 12'h3B0, 32'h0, 1'b1, 32'h1111_1111, 1'b0);
    addAccess(csrPkg::CsrRw, 12'h3B1, 32'hBBBB_BBBB, 1'b1, 32'h2222_2222, 1'b0);
    addAccess(csrPkg::CsrRs, 12'h3B1, 32'h0, 1'b1, 32'h2222_2222, 1'b0);
    addAccess(csrPkg::CsrRw, 12'h3B2, 32'hCCCC_CCCC, 1'b1, 32'h3333_3333, 1'b0);
    addAccess(csrPkg::CsrRs, 12'h3B2, 32'h0, 1'b1, 32'hCCCC_CCCC, 1'b0);
    // Byte 1 keeps its lock, bytes 0 and 2 take new values
    addAccess(csrPkg::CsrRw, 12'h3A0, 32'h0019_0000, 1'b1, 32'h0000_8800, 1'b0);
    addAccess(csrPkg::CsrRs, 12'h3A0, 32'h1, 1'b1, 32'h0019_8800, 1'b0);
    addAccess(csrPkg::CsrRs, 12'h3A0, 32'h0, 1'b1, 32'h0019_8801, 1'b0);
  endtask

  ////////////////////////////////////////////////////////////
  // Drive and check

  task automatic driveRow(input rowT r);
    csrEn     = (r.kind == KindAccess);
    csrOp     = r.op;
    csrAdr    = r.adr;
    csrSrc    = r.src;
    trap      = (r.kind == KindTrap);
    mret      = (r.kind == KindMret);
    trapCause = r.cause;
    trapEpc   = r.epc;
    trapTval  = r.tval;
    mipIn     = r.mip;
  endtask

  task automatic checkRow(input int idx, input rowT r);
    checks++;
    if (r.chkRead && (readVal !== r.expRead)) begin
      errors++;
      $display("ERROR at %0t: row %0d adr %h readVal %h, expected %h",
               $time, idx, r.adr, readVal, r.expRead);
    end
    if (illegal !== r.expIll) begin
      errors++;
      $display("ERROR at %0t: row %0d adr %h illegal %b, expected %b",
               $time, idx, r.adr, illegal, r.expIll);
    end
    if (irqPending !== r.expPend) begin
      errors++;
      $display("ERROR at %0t: row %0d irqPending %b, expected %b",
               $time, idx, irqPending, r.expPend);
    end
    // Cause only matters while an interrupt is pending
    if (r.expPend && (irqCause !== r.expCause)) begin
      errors++;
      $display("ERROR at %0t: row %0d irqCause %h, expected %h",
               $time, idx, irqCause, r.expCause);
    end
    if (mtvec !== r.expMtvec) begin
      errors++;
      $display("ERROR at %0t: row %0d mtvec %h, expected %h",
               $time, idx, mtvec, r.expMtvec);
    end
    if (mepc !== r.expMepc) begin
      errors++;
      $display("ERROR at %0t: row %0d mepc %h, expected %h",
               $time, idx, mepc, r.expMepc);
    end
  endtask

  initial begin
    csrEn     = 1'b0;
    csrOp     = csrPkg::CsrRs;
    csrAdr    = 12'h0;
    csrSrc    = 32'h0;
    trap      = 1'b0;
    trapCause = 5'h0;
    trapEpc   = 32'h0;
    trapTval  = 32'h0;
    mret      = 1'b0;
    mipIn     = 3'b000;
    errors    = 0;
    checks    = 0;
    buildTable();
    tableReady = 1'b1;
    wait (rstN === 1'b1);
    foreach (rows[i]) begin
      @(posedge clk);
      #10;
      driveRow(rows[i]);
      // Outputs are settled well before the next edge
      #50;
      checkRow(i, rows[i]);
    end
    @(posedge clk);
    #10;
    csrEn = 1'b0;
    trap  = 1'b0;
    mret  = 1'b0;
    $display("Rows checked: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Watchdog, ten spare cycles beyond one cycle per row
  initial begin
    int limitNs;
    wait (tableReady);
    limitNs = (rows.size() + 10) * 100;
    #(limitNs);
    $display("Watchdog expired after %0d ns, the run did not finish", limitNs);
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/csrUnit_chk.sv
/*
  Assertions for the machine CSR unit
  Bound into csrUnit so the gated write strobe and
  the mstatus value are visible
*/
`timescale 1ns/1ps
`default_nettype none
`include "csr_params.svh"

module csrUnitChk (
  input logic             clk,
  input logic             rstN,
  input logic             csrEn,
  input logic             illegal,
  input logic             trap,
  input logic             mret,
  input logic             writeEn,
  input logic [11:0]      csrAdr,
  input logic [`XLEN-1:0] mtvec,
  input logic [`XLEN-1:0] mepc,
  input logic [`XLEN-1:0] mstatusReg,
  input logic             irqPending
);

  // An illegal access leaves the registers as they were
  illegalKeepsState: assert property (@(posedge clk) disable iff (!rstN)
    illegal |=> ($stable(mtvec) && $stable(mepc) && $stable(mstatusReg)))
    else $error("register changed after an illegal access");

  // mepc moves only on trap entry or a legal software write
  mepcSource: assert property (@(posedge clk) disable iff (!rstN)
    (mepc != $past(mepc)) |->
      ($past(trap) || ($past(writeEn) && ($past(csrAdr) == csrPkg::AdrMepc))))
    else $error("mepc changed without trap or write");

  // Global enable gates every pending interrupt
  // Trap entry clears the enable so nothing is pending just after
  pendNeedsMie: assert property (@(posedge clk) disable iff (!rstN)
    irqPending |-> (mstatusReg[3] && !$past(trap)))
    else $error("irqPending with mstatus.MIE clear or right after trap");

  // Pipeline never sends both events at once
  noTrapAndMret: assert property (@(posedge clk) disable iff (!rstN) !(trap && mret))
    else $error("trap and mret in the same cycle");

endmodule

`default_nettype wire

//--- tests/tbClock.sv
/*
  Testbench clock and reset
  Free running 100 ns clock, active low reset held
  for four rising edges and released just after one
*/
`timescale 1ns/1ps
`default_nettype none

module tbClock (
  output logic clk,
  output logic rstN
);

  // Half of the 100 ns period
  localparam int HalfPeriod = 50;

  initial begin
    clk = 1'b0;
    forever #(HalfPeriod) clk = ~clk;
  end

  // Release 10 ns after the fourth edge, like all other stimulus
  initial begin
    rstN = 1'b0;
    repeat (4) @(posedge clk);
    #10;
    rstN = 1'b1;
  end

endmodule

`default_nettype wire

//--- rtl/csrUnit.sv
/*
  Machine mode CSR unit, top level
  Builds the write value from the CSR opcode, blocks
  illegal writes and ties the status, interrupt and
  machine register blocks together
*/
`timescale 1ns/1ps
`default_nettype none
`include "csr_params.svh"

module csrUnit (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 csrEn,
  input  csrPkg::csrOpT        csrOp,
  input  logic [11:0]          csrAdr,
  input  logic [`XLEN-1:0]     csrSrc,
  input  logic                 trap,
  input  logic [4:0]           trapCause,
  input  logic [`XLEN-1:0]     trapEpc,
  input  logic [`XLEN-1:0]     trapTval,
  input  logic                 mret,
  input  logic [2:0]           mipIn,
  output logic [`XLEN-1:0]     readVal,
  output logic                 illegal,
  output logic [`XLEN-1:0]     mtvec,
  output logic [`XLEN-1:0]     mepc,
  output logic                 irqPending,
  output logic [4:0]           irqCause
);

  logic             writeTry;
  logic             writeEn;
  logic [`XLEN-1:0] writeVal;
  logic             illegalAccess;
  logic             illegalReadonly;
  logic             writeMstatus;
  logic             writeMie;
  logic [`XLEN-1:0] mstatusReg;
  logic [11:0]      mieReg;
  logic [11:0]      mipReg;

  ////////////////////////////////////////////////////////////
  // Write attempt and new value
  // Set and clear with a zero source are pure reads
  assign writeTry = csrEn & ((csrOp == csrPkg::CsrRw) | (|csrSrc));

  always_comb begin
    case (csrOp)
      csrPkg::CsrRw: writeVal = csrSrc;
      csrPkg::CsrRs: writeVal = readVal | csrSrc;
      csrPkg::CsrRc: writeVal = readVal & ~csrSrc;
      // Unused encoding, write back the old value
      default:       writeVal = readVal;
    endcase
  end

  // Illegal accesses must not touch any state
  assign writeEn = writeTry & ~illegalAccess & ~illegalReadonly;
  assign illegal = csrEn & (illegalAccess | illegalReadonly);

  ////////////////////////////////////////////////////////////
  // Register blocks
  csrm i_csrm (
    .clk             (clk),
    .rstN            (rstN),
    .writeEn         (writeEn),
    .writeTry        (writeTry),
    .csrAdr          (csrAdr),
    .writeVal        (writeVal),
    .trap            (trap),
    .trapCause       (trapCause),
    .trapEpc         (trapEpc),
    .trapTval        (trapTval),
    .mstatusReg      (mstatusReg),
    .mieReg          (mieReg),
    .mipReg          (mipReg),
    .readVal         (readVal),
    .illegalAccess   (illegalAccess),
    .illegalReadonly (illegalReadonly),
    .writeMstatus    (writeMstatus),
    .writeMie        (writeMie),
    .mtvec           (mtvec),
    .mepc            (mepc)
  );

  csrStatus i_csrStatus (
    .clk          (clk),
    .rstN         (rstN),
    .writeMstatus (writeMstatus),
    .writeVal     (writeVal),
    .trap         (trap),
    .mret         (mret),
    .mstatusReg   (mstatusReg)
  );

  // Global enable is mstatus bit 3
  csrInterrupt i_csrInterrupt (
    .clk        (clk),
    .rstN       (rstN),
    .writeMie   (writeMie),
    .writeVal   (writeVal),
    .mipIn      (mipIn),
    .mstatusMie (mstatusReg[3]),
    .mieReg     (mieReg),
    .mipReg     (mipReg),
    .irqPending (irqPending),
    .irqCause   (irqCause)
  );

endmodule

`default_nettype wire

//--- rtl/csrm.sv
/*
  Machine mode CSR file
  Write decode, trap registers, PMP entries with locking,
  the read mux and the illegal access checks.
  mstatus and mie live in their own blocks.
*/
`timescale 1ns/1ps
`default_nettype none
`include "csr_params.svh"

module csrm (
  input  logic             clk,
  input  logic             rstN,
  input  logic             writeEn,
  input  logic             writeTry,
  input  logic [11:0]      csrAdr,
  input  logic [`XLEN-1:0] writeVal,
  input  logic             trap,
  input  logic [4:0]       trapCause,
  input  logic [`XLEN-1:0] trapEpc,
  input  logic [`XLEN-1:0] trapTval,
  input  logic [`XLEN-1:0] mstatusReg,
  input  logic [11:0]      mieReg,
  input  logic [11:0]      mipReg,
  output logic [`XLEN-1:0] readVal,
  output logic             illegalAccess,
  output logic             illegalReadonly,
  output logic             writeMstatus,
  output logic             writeMie,
  output logic [`XLEN-1:0] mtvec,
  output logic [`XLEN-1:0] mepc
);

  logic [`XLEN-1:0]        mscratchReg;
  logic [`XLEN-1:0]        mcauseReg;
  logic [`XLEN-1:0]        mtvalReg;
  logic [`XLEN-1:0]        mcountinhibitReg;
  logic                    writeMtvec;
  logic                    writeMscratch;
  logic                    writeMepc;
  logic                    writeMcause;
  logic                    writeMtval;
  logic                    writeMcountinhibit;
  logic [7:0]              pmpCfg [`PMP_ENTRIES];
  logic [`PA_BITS-3:0]     pmpAddr [`PMP_ENTRIES];
  logic [`PMP_ENTRIES-1:0] cfgLocked;
  logic [`PMP_ENTRIES-1:0] addrLocked;
  logic [`PMP_ENTRIES-1:0] writePmpCfg;
  logic [`PMP_ENTRIES-1:0] writePmpAddr;
  logic                    pmpHit;

  ////////////////////////////////////////////////////////////
  // Write decode, one strobe per register
  assign writeMstatus       = writeEn & (csrAdr == csrPkg::AdrMstatus);
  assign writeMie           = writeEn & (csrAdr == csrPkg::AdrMie);
  assign writeMtvec         = writeEn & (csrAdr == csrPkg::AdrMtvec);
  assign writeMscratch      = writeEn & (csrAdr == csrPkg::AdrMscratch);
  assign writeMepc          = writeEn & (csrAdr == csrPkg::AdrMepc);
  assign writeMcause        = writeEn & (csrAdr == csrPkg::AdrMcause);
  assign writeMtval         = writeEn & (csrAdr == csrPkg::AdrMtval);
  assign writeMcountinhibit = writeEn & (csrAdr == csrPkg::AdrMcountinhibit);

  // Any write attempt to the identity range
  assign illegalReadonly = writeTry & (csrAdr inside {csrPkg::AdrMvendorid, csrPkg::AdrMarchid,
    csrPkg::AdrMimpid, csrPkg::AdrMhartid, csrPkg::AdrMconfigptr});

  // Plain software registers
  always_ff @(posedge clk) begin
    if (!rstN) begin
      mtvec            <= '0;
      mscratchReg      <= '0;
      mcountinhibitReg <= '0;
    end else begin
      // Bit 1 of mtvec is reserved, keep it clear
      if (writeMtvec)         mtvec            <= {writeVal[`XLEN-1:2], 1'b0, writeVal[0]};
      if (writeMscratch)      mscratchReg      <= writeVal;
      if (writeMcountinhibit) mcountinhibitReg <= writeVal;
    end
  end

  // Trap registers, trap entry wins over software
  always_ff @(posedge clk) begin
    if (!rstN) begin
      mepc      <= '0;
      mcauseReg <= '0;
      mtvalReg  <= '0;
    end else if (trap) begin
      mepc      <= trapEpc;
      mtvalReg  <= trapTval;
      mcauseReg <= {trapCause[4], {(`XLEN-5){1'b0}}, trapCause[3:0]};
    end else begin
      if (writeMepc)   mepc      <= writeVal;
      if (writeMtval)  mtvalReg  <= writeVal;
      // Only interrupt flag and a 4 bit code are kept
      if (writeMcause) mcauseReg <= {writeVal[`XLEN-1], {(`XLEN-5){1'b0}}, writeVal[3:0]};
    end
  end

  ////////////////////////////////////////////////////////////
  // PMP entries
  for (genvar i = 0; i < `PMP_ENTRIES; i++) begin : genPmp
    // Locked entry rejects cfg and address writes
    assign cfgLocked[i] = pmpCfg[i][7];
    if (i == `PMP_ENTRIES - 1) begin : genLast
      assign addrLocked[i] = pmpCfg[i][7];
    end else begin : genTor
      // Locked TOR entry above also freezes this address
      assign addrLocked[i] = pmpCfg[i][7] | (pmpCfg[i+1][7] & (pmpCfg[i+1][4:3] == 2'b01));
    end

    // Four cfg bytes per pmpcfg register on RV32
    assign writePmpCfg[i]  = writeEn & (csrAdr == csrPkg::AdrPmpCfg0 + 12'(i / 4))
                           & ~cfgLocked[i];
    assign writePmpAddr[i] = writeEn & (csrAdr == csrPkg::AdrPmpAddr0 + 12'(i))
                           & ~addrLocked[i];

    always_ff @(posedge clk) begin
      if (!rstN) begin
        pmpCfg[i]  <= '0;
        pmpAddr[i] <= '0;
      end else begin
        if (writePmpCfg[i])  pmpCfg[i]  <= writeVal[(i % 4) * 8 +: 8];
        if (writePmpAddr[i]) pmpAddr[i] <= writeVal[`PA_BITS-3:0];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Read mux and illegal address check
  always_comb begin
    readVal       = '0;
    illegalAccess = 1'b0;
    pmpHit        = 1'b0;
    // PMP space first
    for (int k = 0; k < `PMP_ENTRIES; k++) begin
      if (csrAdr == csrPkg::AdrPmpAddr0 + 12'(k)) begin
        readVal = `XLEN'(pmpAddr[k]);
        pmpHit  = 1'b1;
      end
      if (csrAdr == csrPkg::AdrPmpCfg0 + 12'(k / 4)) begin
        readVal[(k % 4) * 8 +: 8] = pmpCfg[k];
        pmpHit = 1'b1;
      end
    end
    if (!pmpHit) begin
      case (csrAdr)
        csrPkg::AdrMvendorid:     readVal = `VENDOR_ID;
        csrPkg::AdrMarchid:       readVal = `ARCH_ID;
        csrPkg::AdrMimpid:        readVal = `IMP_ID;
        // Single hart, no config structure
        csrPkg::AdrMhartid:       readVal = '0;
        csrPkg::AdrMconfigptr:    readVal = '0;
        csrPkg::AdrMisa:          readVal = `MISA_VAL;
        csrPkg::AdrMstatus:       readVal = mstatusReg;
        csrPkg::AdrMstatush:      readVal = '0;
        csrPkg::AdrMie:           readVal = {{(`XLEN-12){1'b0}}, mieReg};
        csrPkg::AdrMip:           readVal = {{(`XLEN-12){1'b0}}, mipReg};
        csrPkg::AdrMtvec:         readVal = mtvec;
        // No lower modes to grant counters to
        csrPkg::AdrMcounteren:    readVal = '0;
        csrPkg::AdrMcountinhibit: readVal = mcountinhibitReg;
        csrPkg::AdrMscratch:      readVal = mscratchReg;
        csrPkg::AdrMepc:          readVal = mepc;
        csrPkg::AdrMcause:        readVal = mcauseReg;
        csrPkg::AdrMtval:         readVal = mtvalReg;
        // Delegation and envcfg need S or U mode
        csrPkg::AdrMedeleg,
        csrPkg::AdrMideleg,
        csrPkg::AdrMenvcfg:       illegalAccess = 1'b1;
        default:                  illegalAccess = 1'b1;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- rtl/csrInterrupt.sv
/*
  Machine interrupt enable and pending logic
  Holds the mie bits, maps the external lines into mip
  and picks the highest priority pending interrupt
*/
`timescale 1ns/1ps
`default_nettype none
`include "csr_params.svh"

module csrInterrupt (
  input  logic             clk,
  input  logic             rstN,
  input  logic             writeMie,
  input  logic [`XLEN-1:0] writeVal,
  input  logic [2:0]       mipIn,
  input  logic             mstatusMie,
  output logic [11:0]      mieReg,
  output logic [11:0]      mipReg,
  output logic             irqPending,
  output logic [4:0]       irqCause
);

  // Enable bits for external, timer and software
  logic [2:0] mieBits;
  // Lines that are both pending and enabled
  logic [11:0] active;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      mieBits <= 3'b000;
    end else if (writeMie) begin
      mieBits <= {writeVal[csrPkg::IrqExt], writeVal[csrPkg::IrqTimer], writeVal[csrPkg::IrqSoft]};
    end
  end

  // Scatter enables and lines into their CSR positions
  // mipIn order is external, timer, software
  always_comb begin
    mieReg = '0;
    mieReg[csrPkg::IrqExt]   = mieBits[2];
    mieReg[csrPkg::IrqTimer] = mieBits[1];
    mieReg[csrPkg::IrqSoft]  = mieBits[0];
    mipReg = '0;
    mipReg[csrPkg::IrqExt]   = mipIn[2];
    mipReg[csrPkg::IrqTimer] = mipIn[1];
    mipReg[csrPkg::IrqSoft]  = mipIn[0];
  end

  assign active     = mipReg & mieReg;
  assign irqPending = mstatusMie & (|active);

  // Priority: external, then software, then timer
  // Cause stays zero unless something is taken
  always_comb begin
    irqCause = 5'b0;
    if (irqPending) begin
      if (active[csrPkg::IrqExt])       irqCause = {1'b1, csrPkg::IrqExt};
      else if (active[csrPkg::IrqSoft]) irqCause = {1'b1, csrPkg::IrqSoft};
      else                              irqCause = {1'b1, csrPkg::IrqTimer};
    end
  end

endmodule

`default_nettype wire

//--- rtl/csrStatus.sv
/*
  mstatus register
  Holds MIE and MPIE, stacks them on trap entry
  and unstacks them on mret. MPP is fixed at machine mode.
*/
`timescale 1ns/1ps
`default_nettype none
`include "csr_params.svh"

module csrStatus (
  input  logic             clk,
  input  logic             rstN,
  input  logic             writeMstatus,
  input  logic [`XLEN-1:0] writeVal,
  input  logic             trap,
  input  logic             mret,
  output logic [`XLEN-1:0] mstatusReg
);

  // Global interrupt enable and its stacked copy
  logic mie;
  logic mpie;

  // Trap and mret take priority over CSR writes
  // They never coincide with a CSR strobe anyway
  always_ff @(posedge clk) begin
    if (!rstN) begin
      mie  <= 1'b0;
      mpie <= 1'b0;
    end else if (trap) begin
      // Stack the enable, block further interrupts
      mpie <= mie;
      mie  <= 1'b0;
    end else if (mret) begin
      // Restore the enable from the stack
      mie  <= mpie;
      mpie <= 1'b1;
    end else if (writeMstatus) begin
      // Only MIE (bit 3) and MPIE (bit 7) are writable
      mie  <= writeVal[3];
      mpie <= writeVal[7];
    end
  end

  // Field layout
  // MPP at 12:11 reads 11, machine mode only
  // Everything else reads zero
  assign mstatusReg = {
    {(`XLEN-13){1'b0}},
    2'b11,
    3'b000,
    mpie,
    3'b000,
    mie,
    3'b000
  };

endmodule

`default_nettype wire

//--- rtl/csrPkg.sv
/*
  Machine CSR unit types
  CSR opcodes, implemented CSR addresses and
  machine interrupt codes
*/
`default_nettype none
`include "csr_params.svh"

package csrPkg;

  // CSR instruction kinds, low bits of funct3
  typedef enum logic [1:0] {
    CsrRw = 2'b01,
    CsrRs = 2'b10,
    CsrRc = 2'b11
  } csrOpT;

  // Implemented machine mode addresses
  typedef enum logic [11:0] {
    AdrMvendorid     = 12'hF11,
    AdrMarchid       = 12'hF12,
    AdrMimpid        = 12'hF13,
    AdrMhartid       = 12'hF14,
    AdrMconfigptr    = 12'hF15,
    AdrMstatus       = 12'h300,
    AdrMisa          = 12'h301,
    AdrMedeleg       = 12'h302,
    AdrMideleg       = 12'h303,
    AdrMie           = 12'h304,
    AdrMtvec         = 12'h305,
    AdrMcounteren    = 12'h306,
    AdrMenvcfg       = 12'h30A,
    AdrMstatush      = 12'h310,
    AdrMcountinhibit = 12'h320,
    AdrMscratch      = 12'h340,
    AdrMepc          = 12'h341,
    AdrMcause        = 12'h342,
    AdrMtval         = 12'h343,
    AdrMip           = 12'h344,
    // Further entries follow at consecutive addresses
    AdrPmpCfg0       = 12'h3A0,
    AdrPmpAddr0      = 12'h3B0
  } csrAdrT;

  // Machine interrupt codes, also the mie and mip bit positions
  typedef enum logic [3:0] {
    IrqSoft  = 4'd3,
    IrqTimer = 4'd7,
    IrqExt   = 4'd11
  } irqCodeT;

endpackage

`default_nettype wire

//--- rtl/csr_params.svh
/*
  Machine CSR unit configuration
  Word width, PMP sizing and the fixed identity values
  of the single supported core configuration
*/
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

// Data word width
`define XLEN 32

// Four PMP entries fit in pmpcfg0 alone
`define PMP_ENTRIES 4

// Physical address width, pmpaddr holds PA_BITS-2 bits
`define PA_BITS 34

// RV32 with I and M extensions
`define MISA_VAL 32'h4000_1100

// Identity registers
`define VENDOR_ID 32'h0000_0000
`define ARCH_ID   32'h0000_0024
`define IMP_ID    32'h0000_0100

`endif
